// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := rvx_dec_exec_tb
FILELIST := vlog.f
OBJ_DIR  := obj_dir
LOG      := sim.log
FAIL_MSG := *** TEST FAILED ***
PASS_MSG := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "make test   build with $(SIM), run and check $(LOG)"
	@echo "make clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "make help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG) || ! grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "result: fail"; exit 1; \
	fi
	@echo "result: pass"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hdl/ex_commit_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "rvx_config.svh"

module ex_commit_regs import rvx_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  ex_result_t result_i,
    input  redirect_t  redirect_i,
    output ex_result_t result_o,
    output redirect_t  redirect_o
);

    logic                   valid_q;
    logic                   illegal_q;
    logic                   reg_wen_q;
    logic                   redir_valid_q;
    logic [`XLEN-1:0]       pc_q;
    logic [`XLEN-1:0]       wdata_q;
    logic [`XLEN-1:0]       target_q;
    logic [`REG_ADDR_W-1:0] rd_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q       <= 1'b0;
            illegal_q     <= 1'b0;
            reg_wen_q     <= 1'b0;
            redir_valid_q <= 1'b0;
        end else begin
            valid_q       <= result_i.valid;
            illegal_q     <= result_i.illegal;
            reg_wen_q     <= result_i.reg_wen;
            redir_valid_q <= redirect_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        pc_q     <= result_i.pc;
        wdata_q  <= result_i.wdata;
        rd_q     <= result_i.rd;
        target_q <= redirect_i.target;
    end

    assign result_o   = '{valid: valid_q, illegal: illegal_q, pc: pc_q, rd: rd_q,
                          reg_wen: reg_wen_q, wdata: wdata_q};
    assign redirect_o = '{valid: redir_valid_q, target: target_q};

endmodule

`default_nettype wire

// File: hdl/id_ex_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "rvx_config.svh"

module id_ex_regs import rvx_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        hold_i,
    input  logic        squash_i,
    input  dec_bundle_t dec_i,
    output dec_bundle_t ex_o
);

    // hold beats squash: a held slot already carries a bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_o    <= '0;
            ex_o.pc <= `RESET_PC;
        end else if (hold_i) begin
            ex_o.valid <= 1'b0;   // payload frozen, bubble out
        end else if (squash_i) begin
            ex_o       <= dec_i;
            ex_o.valid <= 1'b0;   // wrong-path instr behind a taken branch
        end else begin
            ex_o <= dec_i;
        end
    end

endmodule

`default_nettype wire

// File: hdl/rvx_config.svh
`ifndef RVX_CONFIG_SVH
`define RVX_CONFIG_SVH

// datapath and pc width
`define XLEN 64

// architectural register index width
`define REG_ADDR_W 5

// first fetch address after reset
`define RESET_PC 64'h0000_0000_8000_0000

`endif

// File: hdl/rvx_dec_exec_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "rvx_config.svh"

module rvx_dec_exec_top import rvx_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             instr_valid_i,
    input  logic [31:0]      instr_i,
    input  logic [`XLEN-1:0] pc_i,
    input  logic [`XLEN-1:0] rs1_data_i,
    input  logic [`XLEN-1:0] rs2_data_i,
    input  logic             hold_i,
    output ex_result_t       result_o,
    output redirect_t        redirect_o
);

    dec_bundle_t dec_bundle;
    dec_bundle_t ex_bundle;
    ex_result_t  ex_result;
    redirect_t   ex_redirect;

    rvx_decoder i_rvx_decoder (
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .rs1_data_i    (rs1_data_i),
        .rs2_data_i    (rs2_data_i),
        .dec_o         (dec_bundle)
    );

    id_ex_regs i_id_ex_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .hold_i   (hold_i),
        .squash_i (ex_redirect.valid),   // kill the slot behind a taken branch
        .dec_i    (dec_bundle),
        .ex_o     (ex_bundle)
    );

    rvx_execute i_rvx_execute (
        .ex_i       (ex_bundle),
        .result_o   (ex_result),
        .redirect_o (ex_redirect)
    );

    ex_commit_regs i_ex_commit_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .result_i   (ex_result),
        .redirect_i (ex_redirect),
        .result_o   (result_o),
        .redirect_o (redirect_o)
    );

endmodule

`default_nettype wire

// File: hdl/rvx_decoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "rvx_config.svh"

module rvx_decoder import rvx_pkg::*; (
    input  logic              instr_valid_i,
    input  logic [31:0]       instr_i,
    input  logic [`XLEN-1:0]  pc_i,
    input  logic [`XLEN-1:0]  rs1_data_i,
    input  logic [`XLEN-1:0]  rs2_data_i,
    output dec_bundle_t       dec_o
);

    opcode_e          opcode;
    logic [2:0]       funct3;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_j;

    assign opcode = opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];

    assign imm_i = {{(`XLEN-12){instr_i[31]}}, instr_i[31:20]};
    assign imm_u = {{(`XLEN-32){instr_i[31]}}, instr_i[31:12], 12'b0};
    assign imm_b = {{(`XLEN-13){instr_i[31]}}, instr_i[31], instr_i[7],
                    instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_j = {{(`XLEN-21){instr_i[31]}}, instr_i[31], instr_i[19:12],
                    instr_i[20], instr_i[30:21], 1'b0};

    // alt selects sub for OP and the arithmetic right shift
    function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        dec_o          = '0;
        dec_o.valid    = instr_valid_i;
        dec_o.pc       = pc_i;
        dec_o.rs1_data = rs1_data_i;
        dec_o.rs2_data = rs2_data_i;
        dec_o.rd       = instr_i[11:7];
        dec_o.alu_op   = ALU_ADD;
        dec_o.src_a    = SRC_A_RS1;
        dec_o.br_kind  = BR_NONE;
        case (opcode)
            OPC_OP: begin
                dec_o.alu_op  = alu_from_funct3(funct3, instr_i[30]);
                dec_o.reg_wen = 1'b1;
            end
            OPC_OP_IMM: begin
                // addi has no subtract form, only srai uses bit 30
                dec_o.alu_op  = alu_from_funct3(funct3, (funct3 == 3'b101) && instr_i[30]);
                dec_o.use_imm = 1'b1;
                dec_o.imm     = imm_i;
                dec_o.reg_wen = 1'b1;
            end
            OPC_LUI: begin
                dec_o.alu_op  = ALU_PASS_B;
                dec_o.use_imm = 1'b1;
                dec_o.imm     = imm_u;
                dec_o.reg_wen = 1'b1;
            end
            OPC_AUIPC: begin
                dec_o.src_a   = SRC_A_PC;
                dec_o.use_imm = 1'b1;
                dec_o.imm     = imm_u;
                dec_o.reg_wen = 1'b1;
            end
            OPC_JAL: begin
                dec_o.br_kind = BR_JAL;
                dec_o.imm     = imm_j;
                dec_o.reg_wen = 1'b1;
            end
            OPC_JALR: begin
                dec_o.br_kind = BR_JALR;
                dec_o.imm     = imm_i;
                dec_o.reg_wen = 1'b1;
            end
            OPC_BRANCH: begin
                dec_o.imm = imm_b;
                case (funct3)
                    3'b000:  dec_o.br_kind = BR_EQ;
                    3'b001:  dec_o.br_kind = BR_NE;
                    3'b100:  dec_o.br_kind = BR_LT;
                    3'b101:  dec_o.br_kind = BR_GE;
                    3'b110:  dec_o.br_kind = BR_LTU;
                    3'b111:  dec_o.br_kind = BR_GEU;
                    default: dec_o.illegal = 1'b1;   // funct3 010/011 reserved
                endcase
            end
            default: dec_o.illegal = 1'b1;
        endcase
        if (dec_o.rd == '0) begin
            dec_o.reg_wen = 1'b0;   // x0 is hardwired
        end
    end

endmodule

`default_nettype wire

// File: hdl/rvx_execute.sv
`timescale 1ns/1ns
`default_nettype none

`include "rvx_config.svh"

module rvx_execute import rvx_pkg::*; (
    input  dec_bundle_t ex_i,
    output ex_result_t  result_o,
    output redirect_t   redirect_o
);

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [5:0]       shamt;
    logic [`XLEN-1:0] alu_out;
    logic [`XLEN-1:0] jalr_sum;
    logic             is_jump;
    logic             taken;

    always_comb begin
        case (ex_i.src_a)
            SRC_A_PC:   op_a = ex_i.pc;
            SRC_A_ZERO: op_a = '0;
            default:    op_a = ex_i.rs1_data;
        endcase
    end

    assign op_b  = ex_i.use_imm ? ex_i.imm : ex_i.rs2_data;
    assign shamt = op_b[5:0];   // rv64 shifts take 6 bits

    always_comb begin
        case (ex_i.alu_op)
            ALU_ADD:    alu_out = op_a + op_b;
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_SLL:    alu_out = op_a << shamt;
            ALU_SLT:    alu_out = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_out = {{(`XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SRL:    alu_out = op_a >> shamt;
            ALU_SRA:    alu_out = $signed(op_a) >>> shamt;
            ALU_OR:     alu_out = op_a | op_b;
            ALU_AND:    alu_out = op_a & op_b;
            default:    alu_out = op_b;   // pass b for lui
        endcase
    end

    // branch compare always looks at the raw register operands
    always_comb begin
        case (ex_i.br_kind)
            BR_EQ:   taken = ex_i.rs1_data == ex_i.rs2_data;
            BR_NE:   taken = ex_i.rs1_data != ex_i.rs2_data;
            BR_LT:   taken = $signed(ex_i.rs1_data) < $signed(ex_i.rs2_data);
            BR_GE:   taken = $signed(ex_i.rs1_data) >= $signed(ex_i.rs2_data);
            BR_LTU:  taken = ex_i.rs1_data < ex_i.rs2_data;
            BR_GEU:  taken = ex_i.rs1_data >= ex_i.rs2_data;
            BR_JAL,
            BR_JALR: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign is_jump  = (ex_i.br_kind == BR_JAL) || (ex_i.br_kind == BR_JALR);
    assign jalr_sum = ex_i.rs1_data + ex_i.imm;

    always_comb begin
        result_o.valid   = ex_i.valid;
        result_o.illegal = ex_i.illegal;
        result_o.pc      = ex_i.pc;
        result_o.rd      = ex_i.rd;
        result_o.reg_wen = ex_i.valid && ex_i.reg_wen;
        result_o.wdata   = is_jump ? ex_i.pc + `XLEN'd4 : alu_out;   // link value
    end

    always_comb begin
        redirect_o.valid = ex_i.valid && taken;
        if (ex_i.br_kind == BR_JALR) begin
            redirect_o.target = {jalr_sum[`XLEN-1:1], 1'b0};
        end else begin
            redirect_o.target = ex_i.pc + ex_i.imm;
        end
    end

endmodule

`default_nettype wire

// File: hdl/rvx_pkg.sv
`default_nettype none

`include "rvx_config.svh"

package rvx_pkg;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_A_RS1, SRC_A_PC, SRC_A_ZERO
    } src_a_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR
    } br_kind_e;

    // decoded instruction as it travels from ID into EX
    typedef struct packed {
        logic                   valid;
        logic                   illegal;
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       rs1_data;
        logic [`XLEN-1:0]       rs2_data;
        logic [`XLEN-1:0]       imm;
        alu_op_e                alu_op;
        src_a_e                 src_a;
        logic                   use_imm;   // operand b from imm, else rs2
        br_kind_e               br_kind;
        logic                   reg_wen;
        logic [`REG_ADDR_W-1:0] rd;
    } dec_bundle_t;

    typedef struct packed {
        logic                   valid;
        logic                   illegal;
        logic [`XLEN-1:0]       pc;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   reg_wen;
        logic [`XLEN-1:0]       wdata;
    } ex_result_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] target;
    } redirect_t;

endpackage

`default_nettype wire

// File: verification/rvx_dec_exec_props.sv
`timescale 1ns/1ns
`default_nettype none

module rvx_dec_exec_props import rvx_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic       hold_i,
    input logic       squash_i,
    input logic       bundle_valid_i,
    input ex_result_t result_i,
    input redirect_t  redirect_i
);

    reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !bundle_valid_i && !result_i.valid && !result_i.reg_wen && !redirect_i.valid)
        else $error("stage output valid while in reset");

    hold_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        hold_i |=> !bundle_valid_i)
        else $error("id/ex bundle valid after a held cycle");

    squash_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        squash_i |=> !bundle_valid_i)
        else $error("id/ex bundle valid after a squash");

    wen_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        result_i.reg_wen |-> result_i.valid)
        else $error("commit reg_wen set without valid");

endmodule

// sits in the top so both stage registers and their controls are visible
bind rvx_dec_exec_top rvx_dec_exec_props i_rvx_dec_exec_props (
    .clk            (clk),
    .rst_n          (rst_n),
    .hold_i         (hold_i),
    .squash_i       (ex_redirect.valid),
    .bundle_valid_i (ex_bundle.valid),
    .result_i       (result_o),
    .redirect_i     (redirect_o)
);

`default_nettype wire

// File: verification/rvx_dec_exec_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "rvx_config.svh"

module rvx_dec_exec_tb import rvx_pkg::*; ();

    // cycles used by reset, alu, imm, branch, squash, hold and illegal tests
    localparam int TEST_CYCLES = 6 + 22 + 22 + 40 + 3 + 4 + 4;

    logic             clk;
    logic             rst_n;
    logic             instr_valid;
    logic [31:0]      instr;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic             hold;
    ex_result_t       result;
    redirect_t        redirect;
    int               errors;
    int               checks;
    int               tests;

    rvx_dec_exec_top i_rvx_dec_exec_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .pc_i          (pc),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .hold_i        (hold),
        .result_o      (result),
        .redirect_o    (redirect)
    );

    always #5 clk = ~clk;

    function automatic logic [`XLEN-1:0] rnd64();
        return {$urandom, $urandom};
    endfunction

    function automatic logic [`XLEN-1:0] rand_pc();
        return rnd64() & ~`XLEN'd3;   // word aligned
    endfunction

    function automatic logic [31:0] encode_r(input logic [2:0] f3, input logic alt,
                                             input logic [4:0] rd);
        return {1'b0, alt, 5'b0, 5'd2, 5'd1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [2:0] f3,
                                             input logic [4:0] rd, input opcode_e opc);
        return {imm, 5'd1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encode_u(input logic [19:0] imm, input logic [4:0] rd,
                                             input opcode_e opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] encode_b(input logic [12:0] off, input logic [2:0] f3);
        return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] encode_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    // rv64i integer semantics where alt picks sub or arithmetic shift
    function automatic logic [`XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
                                                 input logic [`XLEN-1:0] a,
                                                 input logic [`XLEN-1:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[5:0];
            3'd2: return ($signed(a) < $signed(b)) ? `XLEN'd1 : `XLEN'd0;
            3'd3: return (a < b) ? `XLEN'd1 : `XLEN'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) return $signed(a) >>> b[5:0];
                return a >> b[5:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic void predict(input logic [31:0] ins, input logic [`XLEN-1:0] at_pc,
                                    input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b,
                                    output ex_result_t res, output redirect_t red);
        logic [`XLEN-1:0] imm_i;
        logic [`XLEN-1:0] imm_u;
        logic [`XLEN-1:0] imm_b;
        logic [`XLEN-1:0] imm_j;
        logic [2:0]       f3;
        f3    = ins[14:12];
        imm_i = `XLEN'($signed(ins[31:20]));
        imm_u = `XLEN'($signed({ins[31:12], 12'b0}));
        imm_b = `XLEN'($signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));
        imm_j = `XLEN'($signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}));
        res         = '0;
        red         = '0;
        res.valid   = 1'b1;
        res.pc      = at_pc;
        res.rd      = ins[11:7];
        res.reg_wen = 1'b1;
        case (ins[6:0])
            OPC_OP:     res.wdata = alu_ref(f3, ins[30], a, b);
            OPC_OP_IMM: res.wdata = alu_ref(f3, (f3 == 3'd5) && ins[30], a, imm_i);
            OPC_LUI:    res.wdata = imm_u;
            OPC_AUIPC:  res.wdata = at_pc + imm_u;
            OPC_JAL, OPC_JALR: begin
                res.wdata  = at_pc + `XLEN'd4;   // link
                red.valid  = 1'b1;
                red.target = (ins[6:0] == OPC_JAL) ? at_pc + imm_j : (a + imm_i) & ~`XLEN'd1;
            end
            OPC_BRANCH: begin
                res.reg_wen = 1'b0;
                red.target  = at_pc + imm_b;
                case (f3)
                    3'd0:    red.valid = a == b;
                    3'd1:    red.valid = a != b;
                    3'd4:    red.valid = $signed(a) < $signed(b);
                    3'd5:    red.valid = $signed(a) >= $signed(b);
                    3'd6:    red.valid = a < b;
                    3'd7:    red.valid = a >= b;
                    default: res.illegal = 1'b1;
                endcase
            end
            default: begin
                res.illegal = 1'b1;
                res.reg_wen = 1'b0;
            end
        endcase
        if (res.rd == '0) res.reg_wen = 1'b0;
    endfunction

    task automatic report_mismatch(input string sig, input logic [`XLEN-1:0] want,
                                   input logic [`XLEN-1:0] got);
        errors++;
        $display("mismatch at %0t ns: %s expected %h got %h", $time, sig, want, got);
    endtask

    task automatic check_result(input ex_result_t want, input ex_result_t got);
        checks++;
        if (got.valid !== want.valid)
            report_mismatch("result_o.valid", `XLEN'(want.valid), `XLEN'(got.valid));
        if (got.reg_wen !== want.reg_wen)
            report_mismatch("result_o.reg_wen", `XLEN'(want.reg_wen), `XLEN'(got.reg_wen));
        if (want.valid) begin
            if (got.illegal !== want.illegal)
                report_mismatch("result_o.illegal", `XLEN'(want.illegal), `XLEN'(got.illegal));
            if (got.pc !== want.pc)
                report_mismatch("result_o.pc", want.pc, got.pc);
            if (got.rd !== want.rd)
                report_mismatch("result_o.rd", `XLEN'(want.rd), `XLEN'(got.rd));
            if (want.reg_wen && got.wdata !== want.wdata)
                report_mismatch("result_o.wdata", want.wdata, got.wdata);
        end
    endtask

    task automatic check_redirect(input redirect_t want, input redirect_t got);
        checks++;
        if (got.valid !== want.valid)
            report_mismatch("redirect_o.valid", `XLEN'(want.valid), `XLEN'(got.valid));
        if (want.valid && got.target !== want.target)
            report_mismatch("redirect_o.target", want.target, got.target);
    endtask

    task automatic report_test(input string name, input int err0);
        tests++;
        $display("%-8s %s (%0d errors)", name, (errors == err0) ? "ok" : "failed", errors - err0);
    endtask

    task automatic present_instr(input logic [31:0] ins, input logic [`XLEN-1:0] at_pc,
                                 input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
        instr_valid = 1'b1;
        instr       = ins;
        pc          = at_pc;
        rs1_data    = a;
        rs2_data    = b;
        @(negedge clk);
    endtask

    task automatic go_idle();
        instr_valid = 1'b0;
        @(negedge clk);
    endtask

    // one instruction alone with its result due two cycles after it is presented
    task automatic run_one(input logic [31:0] ins, input logic [`XLEN-1:0] at_pc,
                           input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
        ex_result_t want_res;
        redirect_t  want_red;
        predict(ins, at_pc, a, b, want_res, want_red);
        present_instr(ins, at_pc, a, b);
        go_idle();
        check_result(want_res, result);
        check_redirect(want_red, redirect);
    endtask

    task automatic test_reset();
        ex_result_t quiet_res;
        redirect_t  quiet_red;
        int         err0;
        err0      = errors;
        quiet_res = '0;
        quiet_red = '0;
        check_result(quiet_res, result);
        check_redirect(quiet_red, redirect);
        if (i_rvx_dec_exec_top.ex_bundle.pc !== `RESET_PC)
            report_mismatch("ex_bundle.pc", `RESET_PC, i_rvx_dec_exec_top.ex_bundle.pc);
        report_test("reset", err0);
    endtask

    task automatic test_alu();
        logic [2:0] f3;
        logic       alt;
        int         err0;
        err0 = errors;
        for (int i = 0; i < 11; i++) begin
            f3  = (i < 8) ? 3'(i) : ((i == 9) ? 3'd5 : 3'd0);
            alt = (i == 8) || (i == 9);   // sub, sra
            run_one(encode_r(f3, alt, (i == 10) ? 5'd0 : 5'($urandom)), rand_pc(), rnd64(),
                    rnd64());
        end
        report_test("alu", err0);
    endtask

    task automatic test_imm();
        logic [2:0]       f3_list [9];
        logic [11:0]      imm;
        logic [`XLEN-1:0] a;
        int               err0;
        err0    = errors;
        f3_list = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5};
        for (int i = 0; i < 9; i++) begin
            imm = 12'($urandom);
            a   = rnd64();
            if (f3_list[i] == 3'd1 || f3_list[i] == 3'd5)
                imm[11:6] = (i == 8) ? 6'b010000 : 6'b000000;   // last one is srai
            if (i == 8)
                a[`XLEN-1] = 1'b1;
            run_one(encode_i(imm, f3_list[i], 5'($urandom), OPC_OP_IMM), rand_pc(), a, rnd64());
        end
        run_one(encode_u(20'($urandom), 5'($urandom), OPC_LUI), rand_pc(), rnd64(), rnd64());
        run_one(encode_u(20'($urandom), 5'($urandom), OPC_AUIPC), rand_pc(), rnd64(), rnd64());
        report_test("imm", err0);
    endtask

    task automatic test_branch();
        logic [`XLEN-1:0] lhs [3];
        logic [`XLEN-1:0] rhs [3];
        logic [2:0]       kinds [6];
        logic [`XLEN-1:0] same;
        int               err0;
        err0  = errors;
        same  = rnd64();
        lhs   = '{same, ~`XLEN'd4, `XLEN'd3};   // equal, -5 vs 3, 3 vs -5
        rhs   = '{same, `XLEN'd3, ~`XLEN'd4};
        kinds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        for (int k = 0; k < 6; k++) begin
            for (int p = 0; p < 3; p++) begin
                run_one(encode_b({12'($urandom), 1'b0}, kinds[k]), rand_pc(), lhs[p], rhs[p]);
            end
        end
        run_one(encode_j({20'($urandom), 1'b0}, 5'($urandom)), rand_pc(), rnd64(), rnd64());
        run_one(encode_i(12'($urandom), 3'd0, 5'($urandom), OPC_JALR), rand_pc(), rnd64(),
                rnd64());
        report_test("branch", err0);
    endtask

    task automatic test_squash();
        logic [31:0]      br;
        logic [`XLEN-1:0] at_pc;
        logic [`XLEN-1:0] a;
        ex_result_t       want_res;
        redirect_t        want_red;
        int               err0;
        err0  = errors;
        br    = encode_b(13'd64, 3'd0);
        at_pc = rand_pc();
        a     = rnd64();
        predict(br, at_pc, a, a, want_res, want_red);
        present_instr(br, at_pc, a, a);   // taken beq
        present_instr(encode_i(12'd1, 3'd0, 5'd3, OPC_OP_IMM), at_pc + `XLEN'd4, a, a);
        check_result(want_res, result);
        check_redirect(want_red, redirect);
        go_idle();
        want_res = '0;
        want_red = '0;
        check_result(want_res, result);   // wrong-path addi
        check_redirect(want_red, redirect);
        report_test("squash", err0);
    endtask

    task automatic test_hold();
        logic [31:0]      ins_a;
        logic [31:0]      ins_c;
        logic [`XLEN-1:0] pc_a;
        logic [`XLEN-1:0] pc_c;
        ex_result_t       res_a;
        ex_result_t       res_c;
        ex_result_t       bubble;
        redirect_t        red_a;
        redirect_t        red_c;
        int               err0;
        err0   = errors;
        bubble = '0;
        ins_a  = encode_r(3'd0, 1'b0, 5'd5);
        ins_c  = encode_r(3'd4, 1'b0, 5'd6);
        pc_a   = rand_pc();
        pc_c   = pc_a + `XLEN'd8;
        predict(ins_a, pc_a, `XLEN'd10, `XLEN'd20, res_a, red_a);
        predict(ins_c, pc_c, `XLEN'd12, `XLEN'd5, res_c, red_c);
        present_instr(ins_a, pc_a, `XLEN'd10, `XLEN'd20);
        hold = 1'b1;
        present_instr(encode_r(3'd6, 1'b0, 5'd7), pc_a + `XLEN'd4, rnd64(), rnd64());
        hold = 1'b0;
        check_result(res_a, result);
        check_redirect(red_a, redirect);
        present_instr(ins_c, pc_c, `XLEN'd12, `XLEN'd5);
        check_result(bubble, result);   // held instr is dropped
        go_idle();
        check_result(res_c, result);
        check_redirect(red_c, redirect);
        report_test("hold", err0);
    endtask

    task automatic test_illegal();
        int err0;
        err0 = errors;
        run_one({25'($urandom), 7'b0000011}, rand_pc(), rnd64(), rnd64());   // load opcode
        run_one(encode_b(13'd32, 3'd2), rand_pc(), rnd64(), rnd64());   // reserved funct3
        report_test("illegal", err0);
    endtask

    initial begin
        void'($urandom(92068));
        clk         = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        rs1_data    = '0;
        rs2_data    = '0;
        hold        = 1'b0;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_reset();
        test_alu();
        test_imm();
        test_branch();
        test_squash();
        test_hold();
        test_illegal();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        #((TEST_CYCLES + 100) * 10);
        $display("timeout: tests did not finish within %0d cycles", TEST_CYCLES + 100);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+hdl
hdl/rvx_pkg.sv
hdl/rvx_decoder.sv
hdl/id_ex_regs.sv
hdl/rvx_execute.sv
hdl/ex_commit_regs.sv
hdl/rvx_dec_exec_top.sv
verification/rvx_dec_exec_props.sv
verification/rvx_dec_exec_tb.sv
